//--- build.f
verilog/epd_pkg.sv
verilog/pixel_if.sv
verilog/pixel_decode.sv
verilog/pixel_fifo.sv
verilog/waveform_step.sv
verilog/pixel_pipe_top.sv
tests/pixel_pipe_properties.sv
tests/tb_pixel_pipe.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the pixel pipeline testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_pixel_pipe -o tb_pixel_pipe
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/tb_pixel_pipe 2>&1)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

//--- tests/tb_pixel_pipe.sv
//----------------------------------------------------------------------
// Testbench for the pixel pipeline top level
// Clock and reset, directed and LCG stimulus table with expected values
// from a reference model, random out_ready back-pressure, typed compare
// tasks and a cycle-count timeout
//----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_pixel_pipe;
    import epd_pkg::*;

    // One request and the result it must produce
    typedef struct packed {
        logic [STATE_W-1:0] state;
        logic [PIXEL_W-1:0] pixel;
        logic               set_mode;
        setmode_e           mode_sel;
        pixel_state_t       exp_state;
        drive_e             exp_drive;
    } vec_t;

    logic               clk;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    logic [STATE_W-1:0] in_state;
    logic [PIXEL_W-1:0] in_pixel;
    logic               in_set_mode;
    setmode_e           in_mode_sel;
    logic               out_valid;
    logic               out_ready;
    logic [STATE_W-1:0] out_state;
    drive_e             out_drive;

    vec_t        vecs[$];
    logic [31:0] lcg_state = 32'd23;
    int          cycle_count = 0;
    int          cycle_limit = 100;
    int          err_count = 0;

    pixel_pipe_top u_pixel_pipe_top (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_state    (in_state),
        .in_pixel    (in_pixel),
        .in_set_mode (in_set_mode),
        .in_mode_sel (in_mode_sel),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_state   (out_state),
        .out_drive   (out_drive)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Fast grey start count, white target or black target, by old grey level
    function automatic logic [5:0] grey_start_count(input logic [1:0] old, input logic white);
        if (old == 2'b10) begin
            return white ? 6'd5 : 6'd8;
        end
        if (old == 2'b01) begin
            return white ? 6'd8 : 6'd5;
        end
        return 6'd10;
    endfunction

    // Reference model of one waveform step
    task automatic model_step(input logic [15:0] word, input logic [3:0] pix,
                              input logic set, input setmode_e sel,
                              output pixel_state_t nxt, output drive_e drv);
        pixel_state_t s;
        drive_e       tw;
        logic         changed;
        s = pixel_state_t'(word);
        if (s.mode != FAST_GREY) begin
            s.mode = FAST_MONO;
        end
        tw = pix[3] ? DRIVE_WHITE : DRIVE_BLACK;
        changed = (pix[3:2] != s.prev[1:0]);
        nxt = s;
        drv = NO_DRIVE;
        if (s.mode == FAST_MONO) begin
            if (pix[3] != s.prev[0]) begin
                drv = tw;
                nxt.prev = {3'b000, pix[3]};
                nxt.framecnt = (s.framecnt == 6'd0) ? 6'd10 : 6'd12 - s.framecnt;
            end else if (s.framecnt != 6'd0) begin
                drv = tw;
                nxt.framecnt = s.framecnt - 6'd1;
            end
        end else if (s.stage == MONO) begin
            drv = tw;
            if (changed) begin
                nxt.prev = {2'b00, pix[3:2]};
                nxt.framecnt = 6'd12 - s.framecnt;
            end else if (s.framecnt == 6'd0) begin
                nxt.stage = HOLD;
                nxt.framecnt = 6'd10;
            end else begin
                nxt.framecnt = s.framecnt - 6'd1;
            end
        end else if (s.stage == GREY) begin
            drv = s.prev[1] ? DRIVE_BLACK : DRIVE_WHITE;
            if (s.framecnt == 6'd0) begin
                nxt.stage = DONE;
            end else begin
                nxt.framecnt = s.framecnt - 6'd1;
            end
        end else if (changed) begin
            // DONE or HOLD with a new target
            drv = tw;
            nxt.stage = MONO;
            nxt.prev = {2'b00, pix[3:2]};
            nxt.framecnt = grey_start_count(s.prev[1:0], pix[3]);
        end else if (s.stage == HOLD) begin
            if (s.framecnt != 6'd0) begin
                nxt.framecnt = s.framecnt - 6'd1;
            end else if (s.prev[1:0] == 2'b10 || s.prev[1:0] == 2'b01) begin
                nxt.stage = GREY;
                nxt.framecnt = 6'd1;
            end else begin
                nxt.stage = DONE;
                nxt.framecnt = 6'd0;
            end
        end
        // Preset replaces the state only
        if (set) begin
            if (sel == SETMODE_FAST_GREY) begin
                nxt = '{mode: FAST_GREY, stage: DONE, framecnt: 6'd0, prev: 4'd3};
            end else begin
                nxt = '{mode: FAST_MONO, stage: DONE, framecnt: 6'd0, prev: 4'd1};
            end
        end
    endtask

    task automatic add_vec(input logic [3:0] mode, input logic [1:0] stage,
                           input logic [5:0] cnt, input logic [3:0] prev,
                           input logic [3:0] pix, input logic set, input setmode_e sel);
        vec_t v;
        v.state = {mode, stage, cnt, prev};
        v.pixel = pix;
        v.set_mode = set;
        v.mode_sel = sel;
        model_step(v.state, pix, set, sel, v.exp_state, v.exp_drive);
        vecs.push_back(v);
    endtask

    task automatic add_random_vecs(input int n);
        logic [3:0] mode;
        setmode_e   sel;
        for (int i = 0; i < n; i++) begin
            lcg_state = lcg_next(lcg_state);
            case (lcg_state[9:8])
                2'd0:    mode = 4'd8;
                2'd3:    mode = lcg_state[7:4];
                default: mode = 4'd11;
            endcase
            case (lcg_state[30:29])
                2'd0:    sel = SETMODE_FAST_MONO;
                2'd1:    sel = SETMODE_FAST_GREY;
                default: sel = setmode_e'(lcg_state[31:24]);
            endcase
            add_vec(mode, lcg_state[11:10], lcg_state[17:12], lcg_state[21:18],
                    lcg_state[25:22], lcg_state[28:26] == 3'd0, sel);
        end
    endtask

    task automatic abort_run();
        err_count++;
        $display("STATUS: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_state(input pixel_state_t got, input pixel_state_t exp, input int idx);
        if (got !== exp) begin
            $display("FAIL %0t ns: entry %0d state %h, expected %h", $time, idx, got, exp);
            abort_run();
        end
    endtask

    task automatic check_drive(input drive_e got, input drive_e exp, input int idx);
        if (got !== exp) begin
            $display("FAIL %0t ns: entry %0d drive %0d, expected %0d", $time, idx, got, exp);
            abort_run();
        end
    endtask

    // One request per table entry, held until accepted
    task automatic drive_all();
        foreach (vecs[i]) begin
            in_valid    = 1'b1;
            in_state    = vecs[i].state;
            in_pixel    = vecs[i].pixel;
            in_set_mode = vecs[i].set_mode;
            in_mode_sel = vecs[i].mode_sel;
            do begin
                @(negedge clk);
            end while (!in_ready);
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    // Results in request order, sampled mid-cycle
    task automatic collect_all();
        int idx;
        idx = 0;
        while (idx < vecs.size()) begin
            @(negedge clk);
            if (out_valid && out_ready) begin
                check_state(pixel_state_t'(out_state), vecs[idx].exp_state, idx);
                check_drive(out_drive, vecs[idx].exp_drive, idx);
                idx++;
            end
        end
    endtask

    // Random back-pressure, about three cycles in four ready
    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            lcg_state = lcg_next(lcg_state);
            out_ready = !rst && (lcg_state[31:30] != 2'b00);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: results still missing after %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst         = 1'b1;
        in_valid    = 1'b0;
        in_state    = '0;
        in_pixel    = '0;
        in_set_mode = 1'b0;
        in_mode_sel = SETMODE_FAST_MONO;
        // Fast mono idle, start from rest, reversal, countdown, wrapped reversal
        add_vec(4'd8, 2'd0, 6'd0, 4'd1, 4'h8, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd8, 2'd0, 6'd0, 4'd0, 4'h0, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd8, 2'd0, 6'd0, 4'd0, 4'h9, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd8, 2'd0, 6'd0, 4'd1, 4'h2, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd8, 2'd0, 6'd4, 4'd1, 4'h0, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd8, 2'd0, 6'd3, 4'd1, 4'hC, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd8, 2'd0, 6'd20, 4'd0, 4'hF, 1'b0, SETMODE_FAST_MONO);
        // Fast grey from DONE, three old levels and both targets
        add_vec(4'd11, 2'd0, 6'd0, 4'd2, 4'hC, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd0, 6'd0, 4'd1, 4'hC, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd0, 6'd0, 4'd0, 4'hC, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd0, 6'd0, 4'd2, 4'h0, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd0, 6'd0, 4'd1, 4'h0, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd0, 6'd0, 4'd3, 4'h0, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd0, 6'd0, 4'd3, 4'hC, 1'b0, SETMODE_FAST_MONO);
        // Fast grey MONO, HOLD and GREY progression
        add_vec(4'd11, 2'd1, 6'd0, 4'd3, 4'hC, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd1, 6'd5, 4'd3, 4'hC, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd1, 6'd3, 4'd3, 4'h0, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd2, 6'd3, 4'd2, 4'h8, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd2, 6'd0, 4'd2, 4'h8, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd2, 6'd0, 4'd1, 4'h4, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd2, 6'd0, 4'd3, 4'hC, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd2, 6'd2, 4'd2, 4'h0, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd3, 6'd1, 4'd2, 4'h8, 1'b0, SETMODE_FAST_MONO);
        add_vec(4'd11, 2'd3, 6'd0, 4'd1, 4'h4, 1'b0, SETMODE_FAST_MONO);
        // Set-mode presets, invalid code, unknown stored mode
        add_vec(4'd11, 2'd1, 6'd4, 4'd2, 4'hC, 1'b1, SETMODE_FAST_MONO);
        add_vec(4'd8, 2'd0, 6'd0, 4'd0, 4'h8, 1'b1, SETMODE_FAST_GREY);
        add_vec(4'd8, 2'd0, 6'd6, 4'd1, 4'h0, 1'b1, setmode_e'(8'h77));
        add_vec(4'd3, 2'd2, 6'd0, 4'd0, 4'h8, 1'b0, SETMODE_FAST_MONO);
        add_random_vecs(24);
        cycle_limit = 20 * vecs.size() + 100;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            drive_all();
            collect_all();
        join
        // No result may follow the last expected one
        repeat (10) begin
            @(negedge clk);
            if (out_valid) begin
                $display("Extra result seen after all %0d entries were checked", vecs.size());
                abort_run();
            end
        end
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tests/pixel_pipe_properties.sv
//----------------------------------------------------------------------
// Concurrent assertions on the pipeline output handshake
// Reset clears out_valid, result held steady under back-pressure
//----------------------------------------------------------------------
`timescale 1ns/1ps

module pixel_pipe_properties (
    input logic                         clk,
    input logic                         rst,
    input logic                         out_valid,
    input logic                         out_ready,
    input logic [epd_pkg::STATE_W-1:0]  out_state,
    input epd_pkg::drive_e              out_drive
);

    // Synchronous reset empties the output register
    a_reset_clears_valid: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high after reset");

    // A stalled result stays offered
    a_valid_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped while stalled");

    // Payload frozen while stalled
    a_data_held: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_state) && $stable(out_drive))
        else $error("output data changed while stalled");

endmodule

bind pixel_pipe_top pixel_pipe_properties u_props (.*);

//--- verilog/pixel_pipe_top.sv
//----------------------------------------------------------------------
// Pixel pipeline top level
// Decode stage, job FIFO and waveform stage joined by two
// valid/ready links, plain ports toward the display controller
//----------------------------------------------------------------------
`timescale 1ns/1ps

module pixel_pipe_top (
    input  logic                         clk,
    input  logic                         rst,
    // Request side
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic [epd_pkg::STATE_W-1:0]  in_state,
    input  logic [epd_pkg::PIXEL_W-1:0]  in_pixel,
    input  logic                         in_set_mode,
    input  epd_pkg::setmode_e            in_mode_sel,
    // Result side
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [epd_pkg::STATE_W-1:0]  out_state,
    output epd_pkg::drive_e              out_drive
);

    // Decode to FIFO, and FIFO to waveform step
    pixel_if dec_q ();
    pixel_if step_q ();

    pixel_decode u_decode (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_state    (in_state),
        .in_pixel    (in_pixel),
        .in_set_mode (in_set_mode),
        .in_mode_sel (in_mode_sel),
        .out         (dec_q.source)
    );

    pixel_fifo u_fifo (
        .clk (clk),
        .rst (rst),
        .in  (dec_q.sink),
        .out (step_q.source)
    );

    waveform_step u_step (
        .clk       (clk),
        .rst       (rst),
        .in        (step_q.sink),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_state (out_state),
        .out_drive (out_drive)
    );

endmodule

//--- verilog/waveform_step.sv
//----------------------------------------------------------------------
// Consumer stage of the pixel pipeline
// Fast mono and fast grey waveform step per pixel, set-mode override,
// registered next state and drive code with valid/ready output
//----------------------------------------------------------------------
`timescale 1ns/1ps

module waveform_step (
    input  logic                         clk,
    input  logic                         rst,
    pixel_if.sink                        in,
    output logic                         out_valid,
    input  logic                         out_ready,
    output logic [epd_pkg::STATE_W-1:0]  out_state,
    output epd_pkg::drive_e              out_drive
);
    import epd_pkg::*;

    pixel_state_t       cur;
    pixel_state_t       nxt;
    drive_e             drv;
    drive_e             toward;
    logic [PIXEL_W-1:0] vin;
    logic [5:0]         cnt_dec;
    logic [5:0]         rev_to_white;
    logic [5:0]         rev_to_black;
    logic               grey_changed;

    assign cur = in.state;
    assign vin = in.vin;

    assign cnt_dec = cur.framecnt - 6'd1;
    // Reversal mid-swing, wraps modulo 64 like the counter
    assign rev_to_white = FASTM_B2W_FRAMES - cur.framecnt + 6'd2;
    assign rev_to_black = FASTM_W2B_FRAMES - cur.framecnt + 6'd2;

    // Two-bit grey target against the last settled value
    assign grey_changed = (vin[3:2] != cur.prev[1:0]);

    // MSB of the target picks the rail
    always_comb begin
        if (vin[3]) begin
            toward = DRIVE_WHITE;
        end else begin
            toward = DRIVE_BLACK;
        end
    end

    always_comb begin
        nxt = cur;
        drv = NO_DRIVE;
        case (cur.mode)
            FAST_GREY: begin
                case (cur.stage)
                    DONE, HOLD: begin
                        if (!grey_changed) begin
                            // Settled or waiting out the hold-off
                            if (cur.stage == HOLD) begin
                                if (cur.framecnt != 6'd0) begin
                                    nxt.framecnt = cnt_dec;
                                end else if (cur.prev[1:0] == 2'b10) begin
                                    nxt.stage    = GREY;
                                    nxt.framecnt = FASTG_W2G_FRAMES;
                                end else if (cur.prev[1:0] == 2'b01) begin
                                    nxt.stage    = GREY;
                                    nxt.framecnt = FASTG_B2G_FRAMES;
                                end else begin
                                    // Pure black or white needs no grey pass
                                    nxt.stage    = DONE;
                                    nxt.framecnt = 6'd0;
                                end
                            end
                        end else begin
                            // New target, start with a mono swing
                            drv          = toward;
                            nxt.stage    = MONO;
                            nxt.prev     = {2'b00, vin[3:2]};
                            if (vin[3]) begin
                                case (cur.prev[1:0])
                                    2'b10:   nxt.framecnt = FASTG_LG2W_FRAMES;
                                    2'b01:   nxt.framecnt = FASTG_DG2W_FRAMES;
                                    default: nxt.framecnt = FASTM_B2W_FRAMES;
                                endcase
                            end else begin
                                case (cur.prev[1:0])
                                    2'b10:   nxt.framecnt = FASTG_LG2B_FRAMES;
                                    2'b01:   nxt.framecnt = FASTG_DG2B_FRAMES;
                                    default: nxt.framecnt = FASTM_W2B_FRAMES;
                                endcase
                            end
                        end
                    end
                    MONO: begin
                        drv = toward;
                        if (!grey_changed) begin
                            if (cur.framecnt == 6'd0) begin
                                nxt.stage    = HOLD;
                                nxt.framecnt = FASTG_HOLDOFF_FRAMES;
                            end else begin
                                nxt.framecnt = cnt_dec;
                            end
                        end else begin
                            // Target moved mid-swing, reverse from here
                            nxt.prev     = {2'b00, vin[3:2]};
                            nxt.framecnt = vin[3] ? rev_to_white : rev_to_black;
                        end
                    end
                    default: begin
                        // GREY runs to completion, direction set by old value
                        if (cur.prev[1]) begin
                            drv = DRIVE_BLACK;
                        end else begin
                            drv = DRIVE_WHITE;
                        end
                        if (cur.framecnt == 6'd0) begin
                            nxt.stage = DONE;
                        end else begin
                            nxt.framecnt = cnt_dec;
                        end
                    end
                endcase
            end
            default: begin
                // Fast mono, prev[0] holds the settled colour
                if (vin[3] == cur.prev[0]) begin
                    if (cur.framecnt != 6'd0) begin
                        drv          = toward;
                        nxt.framecnt = cnt_dec;
                    end
                end else begin
                    drv      = toward;
                    nxt.prev = {3'b000, vin[3]};
                    if (cur.framecnt == 6'd0) begin
                        nxt.framecnt = vin[3] ? FASTM_B2W_FRAMES : FASTM_W2B_FRAMES;
                    end else begin
                        nxt.framecnt = vin[3] ? rev_to_white : rev_to_black;
                    end
                end
            end
        endcase
        // Set-mode replaces the stored state, drive is kept
        if (in.set_mode) begin
            nxt = in.preset;
        end
    end

    // Output register empty or draining this edge
    assign in.ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in.valid && in.ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in.valid && in.ready) begin
            out_state <= nxt;
            out_drive <= drv;
        end
    end

endmodule

//--- verilog/pixel_fifo.sv
//----------------------------------------------------------------------
// Job buffer between decode and waveform stages
// Circular FIFO_DEPTH-entry store with read/write pointers and count,
// back-pressure passed upstream through ready
//----------------------------------------------------------------------
`timescale 1ns/1ps

module pixel_fifo (
    input  logic     clk,
    input  logic     rst,
    pixel_if.sink    in,
    pixel_if.source  out
);
    import epd_pkg::*;

    // Job storage, one array per payload field
    pixel_state_t       state_mem  [FIFO_DEPTH];
    logic [PIXEL_W-1:0] vin_mem    [FIFO_DEPTH];
    logic               set_mem    [FIFO_DEPTH];
    pixel_state_t       preset_mem [FIFO_DEPTH];

    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    logic wr_en;
    logic rd_en;
    logic full;

    assign full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    // A full buffer still takes a job when the head leaves this cycle
    assign in.ready = !full || out.ready;

    assign wr_en = in.valid && in.ready;
    assign rd_en = out.valid && out.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own, depth is a power of two
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // When full, the written slot is the head, read out before the edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            state_mem[wr_ptr]  <= in.state;
            vin_mem[wr_ptr]    <= in.vin;
            set_mem[wr_ptr]    <= in.set_mode;
            preset_mem[wr_ptr] <= in.preset;
        end
    end

    // Head of queue, stable until popped
    assign out.valid    = (count != '0);
    assign out.state    = state_mem[rd_ptr];
    assign out.vin      = vin_mem[rd_ptr];
    assign out.set_mode = set_mem[rd_ptr];
    assign out.preset   = preset_mem[rd_ptr];

endmodule

//--- verilog/pixel_decode.sv
//----------------------------------------------------------------------
// Producer stage of the pixel pipeline
// Registers one request, unpacks the stored state with unknown modes
// folded into fast mono, and resolves the set-mode preset
//----------------------------------------------------------------------
`timescale 1ns/1ps

module pixel_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic [epd_pkg::STATE_W-1:0]  in_state,
    input  logic [epd_pkg::PIXEL_W-1:0]  in_pixel,
    input  logic                         in_set_mode,
    input  epd_pkg::setmode_e            in_mode_sel,
    pixel_if.source                      out
);
    import epd_pkg::*;

    pixel_state_t raw_state;
    pixel_state_t job_state;
    pixel_state_t job_preset;

    // Output register, one job deep
    logic               valid_q;
    pixel_state_t       state_q;
    logic [PIXEL_W-1:0] vin_q;
    logic               set_q;
    pixel_state_t       preset_q;

    // Free slot now, or the held job leaves on this edge
    assign in_ready = !valid_q || out.ready;

    // Field view of the VRAM word
    assign raw_state = pixel_state_t'(in_state);

    // Only fast grey keeps its own mode, the rest run as fast mono
    always_comb begin
        job_state = raw_state;
        if (raw_state.mode != FAST_GREY) begin
            job_state.mode = FAST_MONO;
        end
    end

    // Preset lookup, invalid codes fall back to fast mono
    always_comb begin
        case (in_mode_sel)
            SETMODE_FAST_GREY: job_preset = PRESET_FAST_GREY;
            default:           job_preset = PRESET_FAST_MONO;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            valid_q <= 1'b1;
        end else if (out.ready) begin
            valid_q <= 1'b0;
        end
    end

    // Payload only moves on an accepted request
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            state_q  <= job_state;
            vin_q    <= in_pixel;
            set_q    <= in_set_mode;
            preset_q <= job_preset;
        end
    end

    assign out.valid    = valid_q;
    assign out.state    = state_q;
    assign out.vin      = vin_q;
    assign out.set_mode = set_q;
    assign out.preset   = preset_q;

endmodule

//--- verilog/pixel_if.sv
//----------------------------------------------------------------------
// Valid/ready link carrying one decoded pixel job
// Source side drives valid and payload, sink side drives ready
//----------------------------------------------------------------------
`timescale 1ns/1ps

interface pixel_if;
    import epd_pkg::*;

    // Handshake
    logic valid;
    logic ready;

    // Job payload, held while valid is high and ready is low
    pixel_state_t       state;
    logic [PIXEL_W-1:0] vin;
    logic               set_mode;
    // Preset already resolved from the set-mode parameter
    pixel_state_t       preset;

    modport source (
        output valid, state, vin, set_mode, preset,
        input  ready
    );

    modport sink (
        input  valid, state, vin, set_mode, preset,
        output ready
    );

endinterface

//--- verilog/epd_pkg.sv
//----------------------------------------------------------------------
// Shared definitions for the EPD pixel-state pipeline
// Widths and FIFO sizing, stored mode / grey stage / drive / set-mode
// codes, the packed pixel-state layout, fast mono and fast grey frame
// counts, and the two set-mode presets
//----------------------------------------------------------------------
package epd_pkg;

    // Stored pixel state and target pixel widths
    localparam int STATE_W = 16;
    localparam int PIXEL_W = 4;

    // Job buffer between decode and waveform stages
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;

    // Stored mode nibble, only the two fast modes are kept
    typedef enum logic [3:0] {
        FAST_MONO = 4'd8,
        FAST_GREY = 4'd11
    } pixel_mode_e;

    // Fast grey progress through one update
    typedef enum logic [1:0] {
        DONE = 2'd0,
        MONO = 2'd1,
        HOLD = 2'd2,
        GREY = 2'd3
    } grey_stage_e;

    // Panel drive code per pixel
    typedef enum logic [1:0] {
        NO_DRIVE    = 2'd0,
        DRIVE_BLACK = 2'd1,
        DRIVE_WHITE = 2'd2
    } drive_e;

    // Set-mode parameter byte
    // Anything else selects the fast mono preset
    typedef enum logic [7:0] {
        SETMODE_FAST_MONO = 8'd2,
        SETMODE_FAST_GREY = 8'd5
    } setmode_e;

    // 16-bit state as held in VRAM, MSB first
    typedef struct packed {
        pixel_mode_e mode;
        grey_stage_e stage;
        logic [5:0]  framecnt;
        logic [3:0]  prev;
    } pixel_state_t;

    // Fast mono full swing lengths
    localparam logic [5:0] FASTM_B2W_FRAMES = 6'd10;
    localparam logic [5:0] FASTM_W2B_FRAMES = 6'd10;

    // Fast grey settle, grey-in and grey-out lengths
    localparam logic [5:0] FASTG_HOLDOFF_FRAMES = 6'd10;
    localparam logic [5:0] FASTG_B2G_FRAMES     = 6'd1;
    localparam logic [5:0] FASTG_W2G_FRAMES     = 6'd1;
    localparam logic [5:0] FASTG_LG2B_FRAMES    = 6'd8;
    localparam logic [5:0] FASTG_DG2B_FRAMES    = 6'd5;
    localparam logic [5:0] FASTG_LG2W_FRAMES    = 6'd5;
    localparam logic [5:0] FASTG_DG2W_FRAMES    = 6'd8;

    // Presets loaded by set-mode, screen assumed settled
    localparam pixel_state_t PRESET_FAST_MONO =
        '{mode: FAST_MONO, stage: DONE, framecnt: 6'd0, prev: 4'd1};
    localparam pixel_state_t PRESET_FAST_GREY =
        '{mode: FAST_GREY, stage: DONE, framecnt: 6'd0, prev: 4'd3};

endpackage
